/* sim.f */
src/iv_pkg.sv
src/iv_request_capture.sv
src/iv_step_sequencer.sv
src/iv_microstep_rom.sv
src/iv_ctrl_out.sv
src/iv_vector_unit.sv
sim/iv_vector_unit_assert.sv
sim/tb_iv_vector_unit.sv

/* sim/tb_iv_vector_unit.sv */
module tb_iv_vector_unit;
	import iv_pkg::*;

	localparam int CLK_HALF   = 20;            // Period 40
	localparam int RST_CYCLES = 16;
	localparam int HOLD_MAX   = 6;             // Longest run of step_done low
	localparam int SCENARIOS  = 6;
	localparam int TIMEOUT_CYCLES = RST_CYCLES
		+ SCENARIOS * int'(ENTRY_STEPS) * (HOLD_MAX + 1) + 200;

	logic                 clk, rst;
	logic                 iv_enter, iv_return, svc_inst, step_done;
	logic [PRI_W-1:0]     new_curr_pri, curr_pri, prev_pri;
	logic [7:0]           pic_in;
	logic                 operands, word_byte, inc_iv, dec_iv, prpo_iv, iv_cpu_rst;
	logic                 psw_entry_update, clear_cex, load_cex, clr_slp_bit;
	logic                 rec_pre_pri, call_pri_flt, use_pic_vect, rst_counter;
	logic [INST_W-1:0]    inst_type;
	logic [BUS_W-1:0]     data_bus_ctrl_iv, addr_bus_ctrl_iv;
	logic [PSW_SEL_W-1:0] psw_bus_ctrl_iv, psw_ent;
	logic [REG_W-1:0]     data_src_iv, addr_src_iv, data_dst_iv;
	integer               seed;
	int                   hold_cnt;
	int                   cycle_cnt;
	int                   errors;

	iv_vector_unit i_dut (.*);

	bind iv_vector_unit iv_vector_unit_assert i_assert (.*);

	always #CLK_HALF clk = ~clk;

	// Random CPU step completion, never held low past HOLD_MAX
	always @(posedge clk) begin
		if (hold_cnt >= HOLD_MAX || ($random(seed) & 3) == 0) begin
			step_done <= 1'b1;
			hold_cnt  <= 0;
		end else begin
			step_done <= 1'b0;
			hold_cnt  <= hold_cnt + 1;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Closing: %0d assertion failures, 1 timeout", i_dut.i_assert.fail_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// One-cycle request pulse with the priority levels for this routine
	task automatic send_request(input logic enter, input logic ret, input logic trap,
		input logic [PRI_W-1:0] new_pri, input logic [PRI_W-1:0] cur_pri,
		input logic [PRI_W-1:0] prv_pri, input logic [7:0] pic);
		@(posedge clk);
		iv_enter     <= enter;
		iv_return    <= ret;
		svc_inst     <= trap;
		new_curr_pri <= new_pri;                 // Held through the routine
		curr_pri     <= cur_pri;
		prev_pri     <= prv_pri;
		pic_in       <= pic;
		@(posedge clk);
		iv_enter  <= 1'b0;
		iv_return <= 1'b0;
	endtask

	// Final word, then the idle word
	task automatic wait_routine_end();
		while (rst_counter !== 1'b1) begin
			@(posedge clk);
		end
		while (rst_counter === 1'b1) begin
			@(posedge clk);
		end
		@(posedge clk);
	endtask

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		iv_enter     = 1'b0;
		iv_return    = 1'b0;
		svc_inst     = 1'b0;
		step_done    = 1'b0;
		new_curr_pri = '0;
		curr_pri     = '0;
		prev_pri     = '0;
		pic_in       = 8'h00;
		seed         = 64;
		hold_cnt     = 0;
		cycle_cnt    = 0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);

		send_request(1'b1, 1'b0, 1'b0, 3'd5, 3'd3, 3'd0, 8'h00);   // Plain entry
		wait_routine_end();
		send_request(1'b1, 1'b0, 1'b1, 3'd3, 3'd3, 3'd0, 8'h00);   // Trap at equal priority
		wait_routine_end();
		send_request(1'b1, 1'b0, 1'b1, 3'd2, 3'd4, 3'd0, 8'h00);   // Trap lowers priority
		wait_routine_end();
		send_request(1'b0, 1'b1, 1'b0, 3'd0, 3'd4, 3'd2, 8'h00);   // Nothing pending
		wait_routine_end();
		send_request(1'b0, 1'b1, 1'b0, 3'd0, 3'd4, 3'd3, 8'hd0);   // PIC level 5 pending
		wait_routine_end();

		// Tie goes to entry, later pulses land while busy
		send_request(1'b1, 1'b1, 1'b0, 3'd5, 3'd3, 3'd2, 8'h00);
		while (operands !== 1'b1) begin
			@(posedge clk);
		end
		send_request(1'b0, 1'b1, 1'b0, 3'd5, 3'd3, 3'd2, 8'h00);
		send_request(1'b1, 1'b0, 1'b0, 3'd5, 3'd3, 3'd2, 8'h00);
		wait_routine_end();

		repeat (4) @(posedge clk);
		errors = i_dut.i_assert.fail_count;
		$display("Closing: %0d assertion failures, 0 timeouts, %0d cycles", errors, cycle_cnt);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* sim/iv_vector_unit_assert.sv */
module iv_vector_unit_assert
	import iv_pkg::*;
(
	input logic                 clk,
	input logic                 rst,
	input logic                 iv_enter,
	input logic                 iv_return,
	input logic                 svc_inst,
	input logic                 step_done,
	input logic [PRI_W-1:0]     new_curr_pri,
	input logic [PRI_W-1:0]     curr_pri,
	input logic [PRI_W-1:0]     prev_pri,
	input logic [7:0]           pic_in,
	input logic                 operands, word_byte, inc_iv, dec_iv, prpo_iv, iv_cpu_rst,
	input logic                 psw_entry_update, clear_cex, load_cex, clr_slp_bit,
	input logic                 rec_pre_pri, call_pri_flt, use_pic_vect, rst_counter,
	input logic [INST_W-1:0]    inst_type,
	input logic [BUS_W-1:0]     data_bus_ctrl_iv,
	input logic [BUS_W-1:0]     addr_bus_ctrl_iv,
	input logic [PSW_SEL_W-1:0] psw_bus_ctrl_iv,
	input logic [PSW_SEL_W-1:0] psw_ent,
	input logic [REG_W-1:0]     data_src_iv,
	input logic [REG_W-1:0]     addr_src_iv,
	input logic [REG_W-1:0]     data_dst_iv
);

	int          fail_count = 0;              // Read by the testbench at the end
	logic        m_active, o_active;          // m_ tracks the request, o_ the visible word
	iv_kind_t    m_kind, o_kind;
	logic [3:0]  m_step, o_step;
	logic        m_trap;
	logic        m_fault, o_fault;
	logic        m_last;
	logic [13:0] flags;
	logic [53:0] out_word;
	logic        idle_word;
	logic        in_entry, in_return, in_chain;

	// Trap that would lower the priority aborts at step 2
	assign m_fault = m_kind == KIND_ENTRY && m_step == 4'd2 && m_trap
		&& new_curr_pri < curr_pri;
	assign m_last  = m_fault || (m_kind == KIND_ENTRY && m_step == 4'd9)
		|| (m_kind == KIND_RETURN && m_step == 4'd5) || (m_kind == KIND_CHAIN && m_step == 4'd4);

	always_ff @(posedge clk) begin
		o_active <= m_active;                  // Word shows up one edge after the step
		o_step   <= m_step;
		o_kind   <= m_kind;
		o_fault  <= m_fault;
		if (rst) begin
			m_active <= 1'b0;
			m_step   <= 4'd0;
			m_kind   <= KIND_IDLE;
			m_trap   <= 1'b0;
		end else if (!m_active && (iv_enter || iv_return)) begin
			m_active <= 1'b1;
			m_step   <= 4'd1;
			m_trap   <= iv_enter && svc_inst;
			if (iv_enter) begin
				m_kind <= KIND_ENTRY;                  // Entry wins a tie
			end else if (pic_in[7] && pic_in[6:4] >= prev_pri) begin
				m_kind <= KIND_CHAIN;
			end else begin
				m_kind <= KIND_RETURN;
			end
		end else if (m_active && step_done) begin
			m_active <= !m_last;
			m_step   <= m_last ? 4'd0 : m_step + 4'd1;
		end
	end

	assign flags     = {operands, word_byte, inc_iv, dec_iv, prpo_iv, iv_cpu_rst,
		psw_entry_update, clear_cex, load_cex, clr_slp_bit, rec_pre_pri, call_pri_flt,
		use_pic_vect, rst_counter};
	assign out_word  = {flags, inst_type, data_bus_ctrl_iv, addr_bus_ctrl_iv, psw_bus_ctrl_iv,
		psw_ent, data_src_iv, addr_src_iv, data_dst_iv};
	assign idle_word = flags == 14'd0 && inst_type == OP_NONE && data_bus_ctrl_iv == 7'h7f
		&& addr_bus_ctrl_iv == 7'h7f && psw_bus_ctrl_iv == 2'b11 && psw_ent == VEC_PSW
		&& data_src_iv == '0 && addr_src_iv == '0 && data_dst_iv == '0;   // Bus codes all ones
	assign in_entry  = o_active && o_kind == KIND_ENTRY;
	assign in_return = o_active && o_kind == KIND_RETURN;
	assign in_chain  = o_active && o_kind == KIND_CHAIN;

	a_idle: assert property (@(posedge clk) disable iff (rst) !o_active |-> idle_word)
		else begin fail_count++; $error("%0t: outputs not idle outside a routine", $time); end
	a_push_pc: assert property (@(posedge clk) disable iff (rst)
		in_entry && o_step == 4'd2 && !o_fault |->
		inst_type == OP_ST_W && dec_iv && data_src_iv == REG_PC)
		else begin fail_count++; $error("%0t: entry step 2 is not a PC push", $time); end
	a_entry_end: assert property (@(posedge clk) disable iff (rst) in_entry && !o_fault |->
		rst_counter == (o_step == 4'd9) && clear_cex == rst_counter)
		else begin fail_count++; $error("%0t: entry end word on step %0d", $time, o_step); end
	a_fault: assert property (@(posedge clk) disable iff (rst)
		in_entry && o_fault |-> call_pri_flt && rst_counter)
		else begin fail_count++; $error("%0t: trap priority fault missing", $time); end
	a_ret: assert property (@(posedge clk) disable iff (rst) in_return |->
		(o_step != 4'd1 || (load_cex && inc_iv)) && rst_counter == (o_step == 4'd5)
		&& (!rst_counter || data_dst_iv == REG_PC))
		else begin fail_count++; $error("%0t: return word wrong on step %0d", $time, o_step); end
	a_chain: assert property (@(posedge clk) disable iff (rst) in_chain |->
		(o_step != 4'd1 || (rec_pre_pri && inst_type == OP_NONE))
		&& (o_step != 4'd2 || use_pic_vect) && rst_counter == (o_step == 4'd4))
		else begin fail_count++; $error("%0t: chain word wrong on step %0d", $time, o_step); end
	a_end_idle: assert property (@(posedge clk) disable iff (rst)
		rst_counter |=> rst_counter || idle_word)
		else begin fail_count++; $error("%0t: word after the final step not idle", $time); end
	a_hold: assert property (@(posedge clk) disable iff (rst)
		o_active && $past(o_active) && o_step == $past(o_step) |-> $stable(out_word))
		else begin fail_count++; $error("%0t: outputs moved during a hold", $time); end

endmodule

/* src/iv_vector_unit.sv */
module iv_vector_unit
	import iv_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 iv_enter,
	input  logic                 iv_return,
	input  logic                 svc_inst,
	input  logic                 step_done,
	input  logic [PRI_W-1:0]     new_curr_pri,
	input  logic [PRI_W-1:0]     curr_pri,
	input  logic [PRI_W-1:0]     prev_pri,
	input  logic [7:0]           pic_in,
	output logic                 operands,
	output logic                 word_byte,
	output logic                 inc_iv,
	output logic                 dec_iv,
	output logic                 prpo_iv,
	output logic                 iv_cpu_rst,
	output logic                 psw_entry_update,
	output logic                 clear_cex,
	output logic                 load_cex,
	output logic                 clr_slp_bit,
	output logic                 rec_pre_pri,
	output logic                 call_pri_flt,
	output logic                 use_pic_vect,
	output logic                 rst_counter,
	output logic [INST_W-1:0]    inst_type,
	output logic [BUS_W-1:0]     data_bus_ctrl_iv,
	output logic [BUS_W-1:0]     addr_bus_ctrl_iv,
	output logic [PSW_SEL_W-1:0] psw_bus_ctrl_iv,
	output logic [PSW_SEL_W-1:0] psw_ent,
	output logic [REG_W-1:0]     data_src_iv,
	output logic [REG_W-1:0]     addr_src_iv,
	output logic [REG_W-1:0]     data_dst_iv
);

	logic              start;
	iv_kind_t          kind;
	logic              svc_in_prog;
	logic [STEP_W-1:0] step;
	logic              active;
	iv_ctrl_t          ctrl_word;

	iv_request_capture i_request_capture (
		.clk(clk), .rst(rst), .iv_enter(iv_enter), .iv_return(iv_return),
		.svc_inst(svc_inst), .pic_in(pic_in), .prev_pri(prev_pri), .active(active),
		.start(start), .kind(kind), .svc_in_prog(svc_in_prog)
	);

	iv_step_sequencer i_step_sequencer (
		.clk(clk), .rst(rst), .start(start), .step_done(step_done),
		.last_step(ctrl_word.rst_counter), .step(step), .active(active)  // Length from ROM
	);

	iv_microstep_rom i_microstep_rom (
		.kind(kind), .svc_in_prog(svc_in_prog), .step(step), .active(active),
		.new_curr_pri(new_curr_pri), .curr_pri(curr_pri), .ctrl_word(ctrl_word)
	);

	iv_ctrl_out i_ctrl_out (
		.clk(clk), .rst(rst), .ctrl_word(ctrl_word),
		.operands(operands), .word_byte(word_byte), .inc_iv(inc_iv), .dec_iv(dec_iv),
		.prpo_iv(prpo_iv), .iv_cpu_rst(iv_cpu_rst), .psw_entry_update(psw_entry_update),
		.clear_cex(clear_cex), .load_cex(load_cex), .clr_slp_bit(clr_slp_bit),
		.rec_pre_pri(rec_pre_pri), .call_pri_flt(call_pri_flt),
		.use_pic_vect(use_pic_vect), .rst_counter(rst_counter), .inst_type(inst_type),
		.data_bus_ctrl_iv(data_bus_ctrl_iv), .addr_bus_ctrl_iv(addr_bus_ctrl_iv),
		.psw_bus_ctrl_iv(psw_bus_ctrl_iv), .psw_ent(psw_ent), .data_src_iv(data_src_iv),
		.addr_src_iv(addr_src_iv), .data_dst_iv(data_dst_iv)
	);

endmodule

/* src/iv_ctrl_out.sv */
module iv_ctrl_out
	import iv_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  iv_ctrl_t             ctrl_word,         // Word for the current step
	output logic                 operands,
	output logic                 word_byte,
	output logic                 inc_iv,
	output logic                 dec_iv,
	output logic                 prpo_iv,
	output logic                 iv_cpu_rst,
	output logic                 psw_entry_update,
	output logic                 clear_cex,
	output logic                 load_cex,
	output logic                 clr_slp_bit,
	output logic                 rec_pre_pri,
	output logic                 call_pri_flt,
	output logic                 use_pic_vect,
	output logic                 rst_counter,
	output logic [INST_W-1:0]    inst_type,
	output logic [BUS_W-1:0]     data_bus_ctrl_iv,
	output logic [BUS_W-1:0]     addr_bus_ctrl_iv,
	output logic [PSW_SEL_W-1:0] psw_bus_ctrl_iv,
	output logic [PSW_SEL_W-1:0] psw_ent,
	output logic [REG_W-1:0]     data_src_iv,
	output logic [REG_W-1:0]     addr_src_iv,
	output logic [REG_W-1:0]     data_dst_iv
);

	iv_ctrl_t ctrl_q;

	// One cycle behind the step, every field updated together
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl_q <= IV_CTRL_IDLE;
		end else begin
			ctrl_q <= ctrl_word;
		end
	end

	assign operands         = ctrl_q.operands;
	assign word_byte        = ctrl_q.word_byte;
	assign inc_iv           = ctrl_q.inc_iv;
	assign dec_iv           = ctrl_q.dec_iv;
	assign prpo_iv          = ctrl_q.prpo_iv;
	assign iv_cpu_rst       = ctrl_q.iv_cpu_rst;
	assign psw_entry_update = ctrl_q.psw_entry_update;
	assign clear_cex        = ctrl_q.clear_cex;
	assign load_cex         = ctrl_q.load_cex;
	assign clr_slp_bit      = ctrl_q.clr_slp_bit;
	assign rec_pre_pri      = ctrl_q.rec_pre_pri;
	assign call_pri_flt     = ctrl_q.call_pri_flt;
	assign use_pic_vect     = ctrl_q.use_pic_vect;
	assign rst_counter      = ctrl_q.rst_counter;    // Marks the final word
	assign inst_type        = ctrl_q.inst_type;
	assign data_bus_ctrl_iv = ctrl_q.data_bus;
	assign addr_bus_ctrl_iv = ctrl_q.addr_bus;
	assign psw_bus_ctrl_iv  = ctrl_q.psw_bus;
	assign psw_ent          = ctrl_q.psw_ent;
	assign data_src_iv      = ctrl_q.data_src;
	assign addr_src_iv      = ctrl_q.addr_src;
	assign data_dst_iv      = ctrl_q.data_dst;

endmodule

/* src/iv_microstep_rom.sv */
module iv_microstep_rom
	import iv_pkg::*;
(
	input  iv_kind_t          kind,
	input  logic              svc_in_prog,    // Entry started by a trap
	input  logic [STEP_W-1:0] step,
	input  logic              active,
	input  logic [PRI_W-1:0]  new_curr_pri,   // Priority of the vector PSW
	input  logic [PRI_W-1:0]  curr_pri,       // Priority of the running PSW
	output iv_ctrl_t          ctrl_word
);

	logic pri_fault;

	// Trap may not lower the CPU priority
	assign pri_fault = svc_in_prog && (new_curr_pri < curr_pri);

	// Store to stack with SP post decrement
	function automatic iv_ctrl_t push_word(input logic [BUS_W-1:0] dbus,
		input logic [REG_W-1:0] src);
		iv_ctrl_t w;
		w            = IV_CTRL_IDLE;
		w.operands   = 1'b1;
		w.inst_type  = OP_ST_W;
		w.dec_iv     = 1'b1;
		w.data_bus   = dbus;
		w.addr_bus   = ABUS_SP;              // SP into MAR
		w.addr_src   = REG_SP;
		w.data_src   = src;
		w.data_dst   = REG_SP;               // Decremented SP written back
		w.iv_cpu_rst = 1'b1;
		return w;
	endfunction

	// Load from stack with SP pre increment
	function automatic iv_ctrl_t pull_word(input logic [BUS_W-1:0] dbus,
		input logic [REG_W-1:0] dst);
		iv_ctrl_t w;
		w            = IV_CTRL_IDLE;
		w.operands   = 1'b1;
		w.inst_type  = OP_LD_W;
		w.prpo_iv    = 1'b1;
		w.inc_iv     = 1'b1;
		w.data_bus   = dbus;
		w.addr_bus   = ABUS_SP;
		w.addr_src   = REG_SP;
		w.data_src   = REG_SP;               // Base for the load address
		w.data_dst   = dst;
		w.iv_cpu_rst = 1'b1;
		return w;
	endfunction

	// Load one word of the vector entry
	function automatic iv_ctrl_t vec_load(input logic [PSW_SEL_W-1:0] sel,
		input logic [REG_W-1:0] dst);
		iv_ctrl_t w;
		w            = IV_CTRL_IDLE;
		w.operands   = 1'b1;
		w.inst_type  = OP_LD_W;
		w.data_bus   = DBUS_MDR_IN;
		w.addr_bus   = ABUS_VECTOR;
		w.psw_ent    = sel;                  // PSW or entry point word
		w.data_dst   = dst;
		w.iv_cpu_rst = 1'b1;
		return w;
	endfunction

	always_comb begin
		ctrl_word = IV_CTRL_IDLE;              // Unnamed fields stay idle
		if (active) begin
			case (kind)
				KIND_ENTRY: begin
					case (step)
						4'd1: ctrl_word = vec_load(VEC_PSW, REG_TEMP);     // Vector PSW into temp
						4'd2: begin
							if (pri_fault) begin
								ctrl_word.operands     = 1'b1;
								ctrl_word.call_pri_flt = 1'b1;                // Abort into the fault
								ctrl_word.iv_cpu_rst   = 1'b1;
								ctrl_word.rst_counter  = 1'b1;
							end else begin
								ctrl_word = push_word(DBUS_REG_OUT, REG_PC);  // Push PC
							end
						end
						4'd3: ctrl_word = push_word(DBUS_REG_OUT, REG_LR);  // Push LR
						4'd4: ctrl_word = push_word(DBUS_PSW_OUT, REG_LR);  // Push PSW
						4'd5: begin
							ctrl_word = push_word(DBUS_CEX_OUT, REG_LR);      // Push CEX state
							ctrl_word.rec_pre_pri = 1'b1;                     // Keep the old priority
						end
						4'd6: begin
							ctrl_word.operands   = 1'b1;
							ctrl_word.psw_bus    = PSWBUS_FROM_TEMP;          // Install the new PSW
							ctrl_word.data_src   = REG_TEMP;
							ctrl_word.iv_cpu_rst = 1'b1;
						end
						4'd7: begin
							ctrl_word = vec_load(VEC_ENTRY, REG_PC);          // Handler entry into PC
							ctrl_word.psw_entry_update = 1'b1;
							ctrl_word.clr_slp_bit      = 1'b1;
						end
						4'd8: begin
							ctrl_word.operands   = 1'b1;
							ctrl_word.inst_type  = OP_MOV_W;                  // LR gets #FFFF
							ctrl_word.data_bus   = DBUS_MOVE;
							ctrl_word.data_src   = REG_MINUS1;
							ctrl_word.data_dst   = REG_LR;
							ctrl_word.iv_cpu_rst = 1'b1;
						end
						ENTRY_STEPS: begin
							ctrl_word.operands    = 1'b1;
							ctrl_word.clear_cex   = 1'b1;
							ctrl_word.rst_counter = 1'b1;
						end
						default: ctrl_word = IV_CTRL_IDLE;
					endcase
				end
				KIND_RETURN: begin
					case (step)
						4'd1: begin
							ctrl_word = pull_word(DBUS_NONE, REG_SP);          // Pull CEX state
							ctrl_word.load_cex = 1'b1;
						end
						4'd2: begin
							ctrl_word = pull_word(DBUS_NONE, REG_SP);          // Pull PSW
							ctrl_word.psw_bus = PSWBUS_FROM_MDR;
						end
						4'd3: begin
							ctrl_word.operands    = 1'b1;
							ctrl_word.clr_slp_bit = 1'b1;
							ctrl_word.iv_cpu_rst  = 1'b1;
						end
						4'd4: ctrl_word = pull_word(DBUS_MDR_IN, REG_LR);    // Pull LR
						RETURN_STEPS: begin
							ctrl_word = pull_word(DBUS_MDR_IN, REG_PC);        // Pull PC
							ctrl_word.rst_counter = 1'b1;
						end
						default: ctrl_word = IV_CTRL_IDLE;
					endcase
				end
				KIND_CHAIN: begin
					case (step)
						4'd1: begin
							ctrl_word.rec_pre_pri = 1'b1;                      // Stack frame stays
							ctrl_word.iv_cpu_rst  = 1'b1;
						end
						4'd2: begin
							ctrl_word = vec_load(VEC_PSW, REG_TEMP);
							ctrl_word.use_pic_vect = 1'b1;                     // Vector from PIC
						end
						4'd3: begin
							ctrl_word.operands         = 1'b1;
							ctrl_word.psw_bus          = PSWBUS_FROM_TEMP;
							ctrl_word.data_src         = REG_TEMP;
							ctrl_word.psw_entry_update = 1'b1;
							ctrl_word.clr_slp_bit      = 1'b1;
							ctrl_word.iv_cpu_rst       = 1'b1;
						end
						CHAIN_STEPS: begin
							ctrl_word = vec_load(VEC_ENTRY, REG_PC);
							ctrl_word.rst_counter = 1'b1;
						end
						default: ctrl_word = IV_CTRL_IDLE;
					endcase
				end
				default: ctrl_word = IV_CTRL_IDLE;
			endcase
		end
	end

endmodule

/* src/iv_step_sequencer.sv */
module iv_step_sequencer
	import iv_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              start,          // Load step 1
	input  logic              step_done,      // CPU finished the current step
	input  logic              last_step,      // Current word closes the routine
	output logic [STEP_W-1:0] step,           // Current micro-step, 0 when idle
	output logic              active
);

	always_ff @(posedge clk) begin
		if (rst) begin
			step   <= '0;
			active <= 1'b0;
		end else if (start) begin
			step   <= STEP_W'(1);
			active <= 1'b1;
		end else if (active && step_done) begin
			if (last_step) begin
				step   <= '0;             // Routine length set by the ROM
				active <= 1'b0;
			end else begin
				step <= step + 1'b1;
			end
		end
	end

	// Held while step_done stays low

endmodule

/* src/iv_request_capture.sv */
module iv_request_capture
	import iv_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             iv_enter,        // Entry request pulse
	input  logic             iv_return,       // Return request pulse
	input  logic             svc_inst,        // Entry is caused by a trap instruction
	input  logic [7:0]       pic_in,          // Pending flag and priority from PIC
	input  logic [PRI_W-1:0] prev_pri,        // Priority before the current handler
	input  logic             active,          // Routine in progress
	output logic             start,           // Request accepted this cycle
	output iv_kind_t         kind,            // Routine being run
	output logic             svc_in_prog      // Entry was started by a trap
);

	logic accept_enter;
	logic accept_return;
	logic chain_hit;

	// Requests only count while idle, entry wins a tie
	assign accept_enter  = !active && iv_enter;
	assign accept_return = !active && iv_return && !iv_enter;
	assign start         = accept_enter || accept_return;

	// Pending PIC interrupt at or above the previous priority
	assign chain_hit = pic_in[7] && (pic_in[6:4] >= prev_pri);

	always_ff @(posedge clk) begin
		if (rst) begin
			kind        <= KIND_IDLE;
			svc_in_prog <= 1'b0;
		end else if (accept_enter) begin
			kind        <= KIND_ENTRY;
			svc_in_prog <= svc_inst;      // Trap flag held for the fault test
		end else if (accept_return) begin
			kind        <= chain_hit ? KIND_CHAIN : KIND_RETURN;
			svc_in_prog <= 1'b0;
		end else if (!active) begin
			kind        <= KIND_IDLE;     // Drop the routine once the sequencer stops
			svc_in_prog <= 1'b0;
		end
	end

endmodule

/* src/iv_pkg.sv */
package iv_pkg;

	localparam int STEP_W    = 4;                      // Micro-step counter width
	localparam int PRI_W     = 3;                      // CPU priority width
	localparam int INST_W    = 7;                      // Instruction type width
	localparam int REG_W     = 5;                      // Register select width
	localparam int BUS_W     = 7;                      // Data and address bus control width
	localparam int PSW_SEL_W = 2;                      // PSW bus and vector select width

	// Instruction types seen by the CPU cycle logic
	localparam logic [INST_W-1:0] OP_MOV_W = 7'd21;    // MOV.W
	localparam logic [INST_W-1:0] OP_LD_W  = 7'd33;    // LD.W
	localparam logic [INST_W-1:0] OP_ST_W  = 7'd34;    // ST.W
	localparam logic [INST_W-1:0] OP_NONE  = 7'd50;    // Invalid, no datapath action

	// Register file selects
	localparam logic [REG_W-1:0] REG_LR     = 5'd5;    // Link register
	localparam logic [REG_W-1:0] REG_SP     = 5'd6;    // Stack pointer
	localparam logic [REG_W-1:0] REG_PC     = 5'd7;    // Program counter
	localparam logic [REG_W-1:0] REG_MINUS1 = 5'd15;   // Constant #FFFF
	localparam logic [REG_W-1:0] REG_TEMP   = 5'd16;   // Temp holding the vector PSW

	// Data bus controls
	localparam logic [BUS_W-1:0] DBUS_MDR_IN  = 7'b0000001; // MDR into register file
	localparam logic [BUS_W-1:0] DBUS_REG_OUT = 7'b0001000; // Register into MDR
	localparam logic [BUS_W-1:0] DBUS_PSW_OUT = 7'b0100000; // PSW into MDR
	localparam logic [BUS_W-1:0] DBUS_CEX_OUT = 7'b0101000; // CEX state into MDR
	localparam logic [BUS_W-1:0] DBUS_MOVE    = 7'b0001001; // Register to register
	localparam logic [BUS_W-1:0] DBUS_NONE    = 7'b0111111; // No register write from MDR
	localparam logic [BUS_W-1:0] DBUS_IDLE    = 7'b1111111; // Bus not driven by this unit

	// Address bus controls
	localparam logic [BUS_W-1:0] ABUS_SP     = 7'b0001000;  // SP into MAR
	localparam logic [BUS_W-1:0] ABUS_VECTOR = 7'b0100000;  // Vector address into MAR
	localparam logic [BUS_W-1:0] ABUS_IDLE   = 7'b1111111;

	// PSW bus controls
	localparam logic [PSW_SEL_W-1:0] PSWBUS_FROM_MDR  = 2'b01;
	localparam logic [PSW_SEL_W-1:0] PSWBUS_FROM_TEMP = 2'b10;
	localparam logic [PSW_SEL_W-1:0] PSWBUS_IDLE      = 2'b11;

	// Word of the vector entry to address
	localparam logic [PSW_SEL_W-1:0] VEC_PSW   = 2'b00;   // Vector PSW word
	localparam logic [PSW_SEL_W-1:0] VEC_ENTRY = 2'b10;   // Handler entry point word

	// Last step of each routine
	localparam logic [STEP_W-1:0] ENTRY_STEPS  = 4'd9;
	localparam logic [STEP_W-1:0] RETURN_STEPS = 4'd5;
	localparam logic [STEP_W-1:0] CHAIN_STEPS  = 4'd4;

	typedef enum logic [1:0] {
		KIND_IDLE   = 2'd0,                            // No routine latched
		KIND_ENTRY  = 2'd1,                            // Interrupt or trap entry
		KIND_RETURN = 2'd2,                            // Plain return, pulls from stack
		KIND_CHAIN  = 2'd3                             // Return chained into pending PIC vector
	} iv_kind_t;

	typedef struct packed {
		logic                 operands;                // Operands from this unit, not the decoder
		logic                 word_byte;               // 0 for word access
		logic                 inc_iv;
		logic                 dec_iv;
		logic                 prpo_iv;                 // 1 for pre, 0 for post inc or dec
		logic                 iv_cpu_rst;              // CPU cycle restarts at 5 instead of 1
		logic                 psw_entry_update;        // New PSW takes the recorded priority
		logic                 clear_cex;
		logic                 load_cex;                // CEX state from MDR
		logic                 clr_slp_bit;
		logic                 rec_pre_pri;             // Record the current CPU priority
		logic                 call_pri_flt;            // Trap priority fault
		logic                 use_pic_vect;            // Vector number from PIC input
		logic                 rst_counter;             // Final step of the routine
		logic [INST_W-1:0]    inst_type;
		logic [BUS_W-1:0]     data_bus;
		logic [BUS_W-1:0]     addr_bus;
		logic [PSW_SEL_W-1:0] psw_bus;
		logic [PSW_SEL_W-1:0] psw_ent;
		logic [REG_W-1:0]     data_src;
		logic [REG_W-1:0]     addr_src;
		logic [REG_W-1:0]     data_dst;
	} iv_ctrl_t;

	localparam iv_ctrl_t IV_CTRL_IDLE = '{
		operands:         1'b0,
		word_byte:        1'b0,
		inc_iv:           1'b0,
		dec_iv:           1'b0,
		prpo_iv:          1'b0,
		iv_cpu_rst:       1'b0,
		psw_entry_update: 1'b0,
		clear_cex:        1'b0,
		load_cex:         1'b0,
		clr_slp_bit:      1'b0,
		rec_pre_pri:      1'b0,
		call_pri_flt:     1'b0,
		use_pic_vect:     1'b0,
		rst_counter:      1'b0,
		inst_type:        OP_NONE,
		data_bus:         DBUS_IDLE,
		addr_bus:         ABUS_IDLE,
		psw_bus:          PSWBUS_IDLE,
		psw_ent:          VEC_PSW,
		data_src:         '0,
		addr_src:         '0,
		data_dst:         '0
	};

endpackage
